// File: rtl/oq_reg_pkg.sv
package oq_reg_pkg;

   // ----------------------------------------
   // Sizes
   // ----------------------------------------

   // One counter per output queue
   localparam int num_queues       = 8;
   localparam int queue_addr_width = 3;

   // Counter and update widths
   localparam int reg_width        = 32;
   localparam int delta_width      = 16;

   // Host bus data width
   localparam int host_data_width  = 32;

   // ----------------------------------------
   // Basic types
   // ----------------------------------------

   typedef logic [queue_addr_width-1:0] queue_addr_t;
   typedef logic [reg_width-1:0]        counter_t;
   typedef logic [delta_width-1:0]      delta_t;

   // ----------------------------------------
   // Request bundles
   // ----------------------------------------

   // Channel read strobe, valid for one cycle
   typedef struct packed {
      logic        valid;
      queue_addr_t addr;
   } rd_req_t;

   // Channel add-update strobe, valid for one cycle
   typedef struct packed {
      logic        valid;
      queue_addr_t addr;
      delta_t      delta;
   } upd_req_t;

   // Wishbone classic master to slave signals
   typedef struct packed {
      logic                       cyc;
      logic                       stb;
      logic                       we;
      queue_addr_t                adr;
      logic [host_data_width-1:0] dat;
   } wb_req_t;

   // Host request into the engine, held until granted
   typedef struct packed {
      logic        valid;
      logic        we;
      queue_addr_t addr;
      counter_t    data;
   } host_req_t;

endpackage

// File: rtl/queue_state_ram.sv
`timescale 1ns/1ps

module queue_state_ram
   import oq_reg_pkg::*;
   (
      input  logic        clk,

      // Port A, read and write
      input  queue_addr_t addr_a,
      input  logic        we_a,
      input  counter_t    din_a,
      output counter_t    dout_a,

      // Port B, read only
      input  queue_addr_t addr_b,
      output counter_t    dout_b
   );

   // One word per queue
   counter_t mem [num_queues];

   // Start from zero in simulation
   // Hardware gets cleared by host writes after reset
   initial begin
      for (int i = 0; i < num_queues; i++) begin
         mem[i] = '0;
      end
   end

   // ----------------------------------------
   // Port A
   // ----------------------------------------

   // Read-first, so a write cycle returns the old word
   always_ff @(posedge clk) begin
      if (we_a) begin
         mem[addr_a] <= din_a;
      end
      dout_a <= mem[addr_a];
   end

   // ----------------------------------------
   // Port B
   // ----------------------------------------

   always_ff @(posedge clk) begin
      dout_b <= mem[addr_b];
   end

endmodule

// File: rtl/counter_update_engine.sv
`timescale 1ns/1ps

module counter_update_engine
   import oq_reg_pkg::*;
   #(
      // Treat deltas as two's complement
      parameter bit allow_negative = 1'b0
   )
   (
      input  logic        clk,
      input  logic        reset,

      // Channel requests
      input  rd_req_t     rd_a,
      input  logic        rd_b_valid,
      input  upd_req_t    upd_a,

      // Host request and grant
      input  host_req_t   host_req,
      output logic        host_grant,

      // RAM port A
      output queue_addr_t ram_addr,
      output logic        ram_we,
      output counter_t    ram_din,
      input  counter_t    ram_dout,

      // Update completion
      output logic        upd_done,
      output counter_t    upd_value
   );

   // ----------------------------------------
   // State
   // ----------------------------------------

   // Any channel read this cycle
   logic        rd_any;

   // Update request seen alongside a read with its read phase still owed
   logic        held;
   // Update phase that writes the sum back once port A is free
   logic        upd_phase;
   // Update phase was suspended by a read last cycle
   logic        delayed;

   // Captured update request
   queue_addr_t held_addr;
   delta_t      held_delta;

   // Sum at the first suspension
   counter_t    saved_sum;

   // Datapath
   logic        sign_bit;
   counter_t    delta_ext;
   counter_t    cur_sum;
   counter_t    upd_sum;

   // Phase decodes
   logic        upd_read;
   logic        upd_write;

   assign rd_any = rd_a.valid || rd_b_valid;

   // Read phase runs on a new request or a held one
   assign upd_read  = upd_a.valid || held;
   // Reads always win over the write back
   assign upd_write = upd_phase && !rd_any;

   // ----------------------------------------
   // Sum generation
   // ----------------------------------------

   // Sign bit only used when negative deltas are allowed
   assign sign_bit  = allow_negative ? held_delta[delta_width-1] : 1'b0;
   assign delta_ext = {{(reg_width-delta_width){sign_bit}}, held_delta};

   // RAM output shows the target word right after the read phase
   assign cur_sum = ram_dout + delta_ext;

   // After a suspension the RAM output belongs to some other read
   assign upd_sum = delayed ? saved_sum : cur_sum;

   // ----------------------------------------
   // Port A arbitration
   // ----------------------------------------

   always_comb begin
      // Default to the channel A read address
      ram_addr   = rd_a.addr;
      ram_we     = 1'b0;
      ram_din    = upd_sum;
      host_grant = 1'b0;

      if (rd_any) begin
         // Channel read, or a B read that just stalls the update
         ram_addr = rd_a.addr;
      end
      else if (upd_read) begin
         // Fetch the current counter for the add
         ram_addr = upd_a.valid ? upd_a.addr : held_addr;
      end
      else if (upd_phase) begin
         // Write the sum back
         ram_addr = held_addr;
         ram_we   = 1'b1;
         ram_din  = upd_sum;
      end
      else if (host_req.valid) begin
         // Host only gets a fully idle port
         ram_addr   = host_req.addr;
         ram_we     = host_req.we;
         ram_din    = host_req.data;
         host_grant = 1'b1;
      end
   end

   // ----------------------------------------
   // Update state machine
   // ----------------------------------------

   always_ff @(posedge clk) begin
      if (reset) begin
         held      <= 1'b0;
         upd_phase <= 1'b0;
         delayed   <= 1'b0;
      end
      else begin
         // Read phase keeps slipping while reads arrive
         held <= upd_read && rd_any;

         // Enter update after a clean read phase
         // Stay there while reads keep suspending it
         upd_phase <= (upd_read && !rd_any) || (upd_phase && rd_any);

         // Remember the suspension for the next cycle
         delayed <= upd_phase && rd_any;
      end
   end

   // Capture the request payload
   always_ff @(posedge clk) begin
      if (upd_a.valid) begin
         held_addr  <= upd_a.addr;
         held_delta <= upd_a.delta;
      end
   end

   // Keep the sum from the first suspended cycle only
   always_ff @(posedge clk) begin
      if (upd_phase && rd_any && !delayed) begin
         saved_sum <= cur_sum;
      end
   end

   // ----------------------------------------
   // Completion outputs
   // ----------------------------------------

   // Done one clock after the RAM write
   always_ff @(posedge clk) begin
      if (reset) begin
         upd_done <= 1'b0;
      end
      else begin
         upd_done <= upd_write;
      end
   end

   // New value as written
   always_ff @(posedge clk) begin
      if (upd_write) begin
         upd_value <= upd_sum;
      end
   end

endmodule

// File: rtl/wb_host_port.sv
`timescale 1ns/1ps

module wb_host_port
   import oq_reg_pkg::*;
   (
      input  logic                       clk,
      input  logic                       reset,

      // Wishbone classic slave side
      input  wb_req_t                    wb,
      output logic                       wb_ack,
      output logic [host_data_width-1:0] wb_dat,

      // Engine side
      output host_req_t                  host_req,
      input  logic                       host_grant,

      // RAM port A output
      input  counter_t                   ram_dout
   );

   // Bus cycle waiting for service
   logic wb_active;

   // ----------------------------------------
   // Request generation
   // ----------------------------------------

   // Master holds cyc and stb until ack
   // In the ack cycle stb is still high, so block re-issue there
   assign wb_active = wb.cyc && wb.stb && !wb_ack;

   // Request stays up until the engine grants it
   always_comb begin
      host_req.valid = wb_active;
      host_req.we    = wb.we;
      host_req.addr  = wb.adr;
      host_req.data  = wb.dat;
   end

   // ----------------------------------------
   // Acknowledge
   // ----------------------------------------

   // Ack follows the grant by one clock, single cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         wb_ack <= 1'b0;
      end
      else begin
         wb_ack <= host_grant;
      end
   end

   // ----------------------------------------
   // Read data
   // ----------------------------------------

   // RAM output register holds the granted word during the ack cycle
   // Later port A traffic only shows up the cycle after
   // Write acks return the old word, which the master ignores
   assign wb_dat = ram_dout;

endmodule

// File: rtl/oq_reg_group.sv
`timescale 1ns/1ps

module oq_reg_group
   import oq_reg_pkg::*;
   #(
      // Signed deltas with sign extension
      parameter bit allow_negative = 1'b0
   )
   (
      input  logic                       clk,
      input  logic                       reset,

      // Channel A, read and add-update
      input  rd_req_t                    rd_a,
      output counter_t                   rd_data_a,
      input  upd_req_t                   upd_a,
      output logic                       upd_done_a,
      output counter_t                   upd_value_a,

      // Channel B, read only
      input  rd_req_t                    rd_b,
      output counter_t                   rd_data_b,

      // Host Wishbone slave
      input  wb_req_t                    wb,
      output logic                       wb_ack,
      output logic [host_data_width-1:0] wb_dat
   );

   // ----------------------------------------
   // Internal wires
   // ----------------------------------------

   // RAM port A control from the engine
   queue_addr_t ram_addr_a;
   logic        ram_we_a;
   counter_t    ram_din_a;

   // Host handshake
   host_req_t   host_req;
   logic        host_grant;

   // ----------------------------------------
   // Counter storage
   // ----------------------------------------

   // Port B serves channel B reads directly
   // Port A output doubles as channel A read data
   queue_state_ram ram_inst (
      .clk    (clk),
      .addr_a (ram_addr_a),
      .we_a   (ram_we_a),
      .din_a  (ram_din_a),
      .dout_a (rd_data_a),
      .addr_b (rd_b.addr),
      .dout_b (rd_data_b)
   );

   // ----------------------------------------
   // Port A arbitration and updates
   // ----------------------------------------

   counter_update_engine #(
      .allow_negative (allow_negative)
   ) engine_inst (
      .clk        (clk),
      .reset      (reset),
      .rd_a       (rd_a),
      .rd_b_valid (rd_b.valid),
      .upd_a      (upd_a),
      .host_req   (host_req),
      .host_grant (host_grant),
      .ram_addr   (ram_addr_a),
      .ram_we     (ram_we_a),
      .ram_din    (ram_din_a),
      .ram_dout   (rd_data_a),
      .upd_done   (upd_done_a),
      .upd_value  (upd_value_a)
   );

   // ----------------------------------------
   // Host access
   // ----------------------------------------

   wb_host_port host_inst (
      .clk        (clk),
      .reset      (reset),
      .wb         (wb),
      .wb_ack     (wb_ack),
      .wb_dat     (wb_dat),
      .host_req   (host_req),
      .host_grant (host_grant),
      .ram_dout   (rd_data_a)
   );

endmodule

// File: test/oq_reg_group_tb.sv
`timescale 1ns/1ps

module oq_reg_group_tb
   import oq_reg_pkg::*;
   ();

   // ----------------------------------------
   // Constants and types
   // ----------------------------------------

   localparam int clk_period  = 100;
   localparam int wait_limit  = 20;
   localparam int upd_spacing = 8;
   localparam int num_random  = 24;

   // Step kinds of the stimulus table
   typedef enum logic [2:0] {
      k_host_wr, k_host_rd, k_read, k_update, k_upd_host, k_rand_upd
   } step_kind_t;

   // Channel field selects A, B or both for reads
   // For updates it selects a late read start
   typedef struct packed {
      step_kind_t  kind;
      logic [1:0]  chan;
      queue_addr_t queue;
      counter_t    value;
      logic [3:0]  reads;
      logic        has_exp;
      counter_t    expected;
   } step_t;

   logic     clk;
   logic     reset;
   rd_req_t  rd_a;
   rd_req_t  rd_b;
   upd_req_t upd_a;
   wb_req_t  wb;
   counter_t rd_data_a;
   counter_t rd_data_b;
   counter_t upd_value_a;
   logic     upd_done_a;
   logic     wb_ack;
   logic [host_data_width-1:0] wb_dat;

   // One reference counter per queue
   counter_t model [num_queues];
   step_t    steps [$];
   int       errors;
   int       checks;
   int       seed = 80;
   bit       table_ready;

   oq_reg_group #(
      .allow_negative (1'b1)
   ) oq_reg_group_inst (
      .clk         (clk),
      .reset       (reset),
      .rd_a        (rd_a),
      .rd_data_a   (rd_data_a),
      .upd_a       (upd_a),
      .upd_done_a  (upd_done_a),
      .upd_value_a (upd_value_a),
      .rd_b        (rd_b),
      .rd_data_b   (rd_data_b),
      .wb          (wb),
      .wb_ack      (wb_ack),
      .wb_dat      (wb_dat)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period/2) clk = ~clk;
   end

   // ----------------------------------------
   // Helpers
   // ----------------------------------------

   // Two's complement delta widened to counter width
   function automatic counter_t sign_extend(delta_t d);
      return counter_t'($signed(d));
   endfunction

   task automatic add_step(step_kind_t kind, logic [1:0] chan, queue_addr_t queue,
                           counter_t value, logic [3:0] reads, logic has_exp,
                           counter_t expected);
      step_t st;
      st = {kind, chan, queue, value, reads, has_exp, expected};
      steps.push_back(st);
   endtask

   task automatic check_val(int idx, string what, counter_t exp, counter_t act);
      checks++;
      assert (act === exp)
      else begin
         errors++;
         $display("MISMATCH step %0d %s: expected %h, actual %h", idx, what, exp, act);
      end
   endtask

   task automatic check_true(int idx, bit cond, string msg);
      checks++;
      assert (cond)
      else begin
         errors++;
         $display("ERROR step %0d: %s", idx, msg);
      end
   endtask

   // One read cycle with data checked one clock after the strobe
   task automatic chan_read(int idx, bit use_a, bit use_b, queue_addr_t qa, queue_addr_t qb,
                            counter_t exp_a, counter_t exp_b);
      rd_a.valid = use_a;
      rd_a.addr  = qa;
      rd_b.valid = use_b;
      rd_b.addr  = qb;
      @(negedge clk);
      // Update strobe is one cycle wide
      upd_a.valid = 1'b0;
      rd_a.valid  = 1'b0;
      rd_b.valid  = 1'b0;
      if (use_a) check_val(idx, "channel A read", exp_a, rd_data_a);
      if (use_b) check_val(idx, "channel B read", exp_b, rd_data_b);
   endtask

   // Wishbone classic cycle with B reads in the way for rd_busy cycles
   task automatic host_access(int idx, bit we, queue_addr_t q, counter_t data, int rd_busy,
                              output counter_t rdata, output bit acked);
      int n;
      n     = 0;
      acked = 1'b0;
      rdata = '0;
      wb.cyc = 1'b1;
      wb.stb = 1'b1;
      wb.we  = we;
      wb.adr = q;
      wb.dat = data;
      rd_b.valid = (rd_busy > 0);
      rd_b.addr  = q;
      while (!acked && n < wait_limit) begin
         @(negedge clk);
         n++;
         upd_a.valid = 1'b0;
         rd_b.valid  = (n < rd_busy);
         if (wb_ack) begin
            acked = 1'b1;
            rdata = wb_dat;
         end
      end
      // Master drops the cycle right after ack
      wb.cyc = 1'b0;
      wb.stb = 1'b0;
      check_true(idx, acked, "no Wishbone ack within the wait limit");
   endtask

   // Add-update with reads alongside and a final read of the new value
   task automatic run_update(int idx, step_t st, bit random_reads);
      counter_t    expect_new;
      queue_addr_t rq;
      int          cyc;
      int          n;
      expect_new  = st.has_exp ? st.expected :
                    model[st.queue] + sign_extend(st.value[delta_width-1:0]);
      upd_a.valid = 1'b1;
      upd_a.addr  = st.queue;
      upd_a.delta = st.value[delta_width-1:0];
      cyc = 0;
      // Late start lets the update enter its write phase first
      if (st.reads == 0 || st.chan == 2'd1) begin
         @(negedge clk);
         upd_a.valid = 1'b0;
         cyc++;
      end
      for (int i = 0; i < st.reads; i++) begin
         rq = random_reads ? queue_addr_t'($random(seed)) : st.queue + queue_addr_t'(i);
         // Old values until the update completes
         chan_read(idx, i % 2 == 0, i % 2 == 1, rq, rq, model[rq], model[rq]);
         cyc++;
         check_true(idx, !upd_done_a, "update finished while reads were still arriving");
      end
      n = 0;
      while (!upd_done_a && n < wait_limit) begin
         @(negedge clk);
         n++;
      end
      cyc += n;
      check_true(idx, upd_done_a, "no update done within the wait limit");
      if (upd_done_a) check_val(idx, "update value", expect_new, upd_value_a);
      model[st.queue] = model[st.queue] + sign_extend(st.value[delta_width-1:0]);
      // Read in the done cycle sees the written word
      chan_read(idx, 1'b1, 1'b0, st.queue, st.queue, model[st.queue], '0);
      cyc++;
      // Keep updates at least 8 cycles apart
      while (cyc < upd_spacing) begin
         @(negedge clk);
         cyc++;
      end
   endtask

   task automatic run_step(int idx, step_t st);
      counter_t    rdata;
      counter_t    exp;
      counter_t    exp_b;
      queue_addr_t qb;
      bit          acked;
      exp = st.has_exp ? st.expected : model[st.queue];
      case (st.kind)
         k_host_wr: begin
            host_access(idx, 1'b1, st.queue, st.value, st.reads, rdata, acked);
            if (acked) model[st.queue] = st.value;
         end
         k_host_rd: begin
            host_access(idx, 1'b0, st.queue, '0, st.reads, rdata, acked);
            if (acked) check_val(idx, "host read", exp, rdata);
         end
         k_read: begin
            // Both channels read neighbouring queues
            if (st.chan == 2'd2) qb = st.queue + 3'd1;
            else qb = st.queue;
            exp_b = (st.chan == 2'd1) ? exp : model[qb];
            chan_read(idx, st.chan != 2'd1, st.chan != 2'd0, st.queue, qb, exp, exp_b);
         end
         k_update:   run_update(idx, st, 1'b0);
         k_rand_upd: run_update(idx, st, 1'b1);
         default: begin
            // Host read posted together with an update to the same queue
            upd_a.valid = 1'b1;
            upd_a.addr  = st.queue;
            upd_a.delta = st.value[delta_width-1:0];
            host_access(idx, 1'b0, st.queue, '0, 0, rdata, acked);
            model[st.queue] = model[st.queue] + sign_extend(st.value[delta_width-1:0]);
            if (acked) check_val(idx, "host read after update", exp, rdata);
            check_val(idx, "update value", exp, upd_value_a);
         end
      endcase
   endtask

   // ----------------------------------------
   // Stimulus table
   // ----------------------------------------

   task automatic build_table();
      queue_addr_t rq;
      delta_t      rdelta;
      logic [3:0]  rn;
      logic [1:0]  rl;
      for (int q = 0; q < num_queues; q++)
         add_step(k_host_wr, 0, q, 32'h1000_0000 + q * 32'h111, 0, 0, '0);
      for (int q = 0; q < num_queues; q++)
         add_step(k_host_rd, 0, q, '0, 0, 1, 32'h1000_0000 + q * 32'h111);
      add_step(k_read, 0, 3, '0, 0, 1, 32'h1000_0333);
      add_step(k_read, 1, 5, '0, 0, 1, 32'h1000_0555);
      add_step(k_read, 2, 6, '0, 0, 0, '0);
      add_step(k_update, 0, 2, 32'h0025, 0, 1, 32'h1000_0247);
      // Negative delta through sign extension
      add_step(k_update, 0, 4, 32'hfff0, 0, 1, 32'h1000_0434);
      add_step(k_read, 0, 4, '0, 0, 1, 32'h1000_0434);
      // Suspended write phase followed by a held read phase
      add_step(k_update, 1, 1, 32'h0100, 3, 1, 32'h1000_0211);
      add_step(k_update, 0, 7, 32'h8000, 2, 1, 32'h0fff_8777);
      add_step(k_upd_host, 0, 5, 32'h0003, 0, 1, 32'h1000_0558);
      add_step(k_host_rd, 0, 6, '0, 3, 0, '0);
      add_step(k_host_wr, 0, 3, '0, 2, 0, '0);
      add_step(k_read, 0, 3, '0, 0, 1, '0);
      for (int i = 0; i < num_random; i++) begin
         rq     = $random(seed);
         rdelta = $random(seed);
         rn     = $random(seed) & 3;
         rl     = $random(seed) & 1;
         add_step(k_rand_upd, rl, rq, counter_t'(rdelta), rn, 0, '0);
      end
      for (int q = 0; q < num_queues; q++)
         add_step(k_host_rd, 0, q, '0, 0, 0, '0);
   endtask

   // ----------------------------------------
   // Main sequence and watchdog
   // ----------------------------------------

   initial begin
      reset  = 1'b1;
      rd_a   = '0;
      rd_b   = '0;
      upd_a  = '0;
      wb     = '0;
      errors = 0;
      checks = 0;
      // RAM starts cleared
      foreach (model[i]) model[i] = '0;
      build_table();
      table_ready = 1'b1;
      // Two rising edges under reset
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      check_true(0, !upd_done_a, "upd_done_a high after reset");
      check_true(0, !wb_ack, "wb_ack high after reset");
      foreach (steps[i]) run_step(i + 1, steps[i]);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

   initial begin
      wait (table_ready);
      #(steps.size() * 20 * clk_period);
      $display("Timeout: run did not finish within %0d cycles", steps.size() * 20);
      $display("checks %0d, errors %0d", checks, errors);
      $display("Something failed");
      $finish;
   end

endmodule

// File: src.f
rtl/oq_reg_pkg.sv
rtl/queue_state_ram.sv
rtl/counter_update_engine.sv
rtl/wb_host_port.sv
rtl/oq_reg_group.sv
test/oq_reg_group_tb.sv

// File: Bender.yml
package:
  name: oq_reg_group

sources:
  # Design, in compile order
  - rtl/oq_reg_pkg.sv
  - rtl/queue_state_ram.sv
  - rtl/counter_update_engine.sv
  - rtl/wb_host_port.sv
  - rtl/oq_reg_group.sv

  # Testbench
  - target: test
    files:
      - test/oq_reg_group_tb.sv
